/* logic/axi_bus_pkg.sv */
// --------------------------------------
// AXI4 channel payloads, burst and response encodings and the bundled
// request/response structs used on both sides of the burst splitter
// --------------------------------------
package axi_bus_pkg;

  // --------------------------------------
  // Bus widths
  // --------------------------------------
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // One strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  // Beat count minus one
  typedef logic [7:0]           len_t;
  // Log2 of bytes per beat
  typedef logic [2:0]           size_t;

  // Encodings follow the AXI4 specification
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Ordered by severity, so a larger value is a worse response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // --------------------------------------
  // Channel payloads
  // --------------------------------------
  // Shared by AR and AW
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Pick the more severe of two responses
  function automatic resp_e worse_resp(resp_e a, resp_e b);
    return (a > b) ? a : b;
  endfunction

endpackage

/* logic/split_pkg.sv */
// --------------------------------------
// Bookkeeping types for the burst splitter: FSM states, the per-burst
// counter entry and helpers that build and inspect entries
// --------------------------------------
package split_pkg;

  // Splitter FSM
  typedef enum logic {
    SplitIdle,
    SplitBusy
  } split_state_e;

  // R rebuild, holds the last flag under back-pressure
  typedef enum logic {
    HoldPass,
    HoldWait
  } hold_state_e;

  // Beats still owed, up to 256 so one extra bit over len
  typedef logic [8:0] beats_t;

  typedef struct packed {
    logic                busy;
    axi_bus_pkg::id_t    id;
    beats_t              remaining;
    // Worst response so far, only the write side folds into it
    axi_bus_pkg::resp_e  resp;
  } cnt_entry_t;

  // Fresh entry for a burst accepted upstream
  function automatic cnt_entry_t new_entry(axi_bus_pkg::ax_chan_t ax);
    cnt_entry_t e;
    e.busy      = 1'b1;
    e.id        = ax.id;
    e.remaining = {1'b0, ax.len} + beats_t'(1);
    e.resp      = axi_bus_pkg::RESP_OKAY;
    return e;
  endfunction

  // Entry is emptied by the next consumed beat
  function automatic logic last_beat(cnt_entry_t e);
    return e.remaining == beats_t'(1);
  endfunction

endpackage

/* logic/beat_counters.sv */
// --------------------------------------
// Table of outstanding bursts for one direction. Allocated per accepted
// burst, looked up by ID, oldest burst of an ID answers first
// --------------------------------------
`timescale 1ns/100ps

module beat_counters #(
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Allocation, id and len taken from the burst
  input  axi_bus_pkg::ax_chan_t alloc_ax_i,
  input  logic                  alloc_req_i,
  output logic                  alloc_gnt_o,
  // Lookup and consume from the response side
  input  axi_bus_pkg::id_t      lookup_id_i,
  input  logic                  lookup_req_i,
  output logic                  lookup_gnt_o,
  output axi_bus_pkg::len_t     lookup_left_o,
  input  logic                  consume_i,
  input  axi_bus_pkg::resp_e    consume_resp_i,
  output axi_bus_pkg::resp_e    worst_resp_o
);
  import axi_bus_pkg::*;
  import split_pkg::*;

  localparam int unsigned IdxWidth = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  cnt_entry_t [MAX_TXNS-1:0] entry_q, entry_d;
  // Age rank, 0 is the oldest live entry
  idx_t [MAX_TXNS-1:0]       age_q, age_d;
  idx_t                      free_idx, hit_idx;
  logic                      any_free, any_hit;
  logic [IdxWidth:0]         busy_cnt;
  logic                      alloc_en, consume_en, release_en;

  // --------------------------------------
  // Free slot and oldest-match search
  // --------------------------------------
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    any_hit  = 1'b0;
    hit_idx  = '0;
    busy_cnt = '0;
    for (int unsigned i = 0; i < MAX_TXNS; i++) begin
      if (entry_q[i].busy) begin
        busy_cnt = busy_cnt + 1'b1;
        // Among entries of this ID keep the lowest rank
        if (entry_q[i].id == lookup_id_i && (!any_hit || age_q[i] < age_q[hit_idx])) begin
          any_hit = 1'b1;
          hit_idx = idx_t'(i);
        end
      end else if (!any_free) begin
        // Lowest free index wins
        any_free = 1'b1;
        free_idx = idx_t'(i);
      end
    end
  end

  assign alloc_gnt_o   = any_free;
  assign lookup_gnt_o  = lookup_req_i & any_hit;
  assign lookup_left_o = len_t'(entry_q[hit_idx].remaining - beats_t'(1));
  assign worst_resp_o  = entry_q[hit_idx].resp;

  assign alloc_en   = alloc_req_i & any_free;
  assign consume_en = lookup_gnt_o & consume_i;
  assign release_en = consume_en & last_beat(entry_q[hit_idx]);

  // --------------------------------------
  // Entry and rank update
  // --------------------------------------
  always_comb begin
    entry_d = entry_q;
    age_d   = age_q;
    if (release_en) begin
      entry_d[hit_idx].busy = 1'b0;
      // Younger entries move up one rank
      for (int unsigned i = 0; i < MAX_TXNS; i++) begin
        if (entry_q[i].busy && age_q[i] > age_q[hit_idx]) begin
          age_d[i] = age_q[i] - 1'b1;
        end
      end
    end else if (consume_en) begin
      entry_d[hit_idx].remaining = entry_q[hit_idx].remaining - beats_t'(1);
      entry_d[hit_idx].resp      = worse_resp(entry_q[hit_idx].resp, consume_resp_i);
    end
    // Slot being freed this cycle is still busy, so no clash with allocation
    if (alloc_en) begin
      entry_d[free_idx] = new_entry(alloc_ax_i);
      age_d[free_idx]   = idx_t'(busy_cnt - release_en);
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
      age_q   <= '0;
    end else begin
      entry_q <= entry_d;
      age_q   <= age_d;
    end
  end

endmodule

/* logic/ax_splitter.sv */
// --------------------------------------
// Breaks one AR or AW burst into single-beat requests and claims a beat
// counter when the burst is accepted. Instantiated once per direction
// --------------------------------------
`timescale 1ns/100ps

module ax_splitter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Upstream burst
  input  axi_bus_pkg::ax_chan_t ax_i,
  input  logic                  ax_valid_i,
  output logic                  ax_ready_o,
  // Downstream single beats
  output axi_bus_pkg::ax_chan_t ax_o,
  output logic                  ax_valid_o,
  input  logic                  ax_ready_i,
  // Counter allocation
  output logic                  alloc_req_o,
  input  logic                  alloc_gnt_i
);
  import axi_bus_pkg::*;
  import split_pkg::*;

  split_state_e state_q, state_d;
  // Rest of the burst, len counts beats after the one on offer
  ax_chan_t     burst_q, burst_d;

  // Step to the following beat
  function automatic ax_chan_t next_beat(ax_chan_t ax);
    ax_chan_t nx;
    nx     = ax;
    nx.len = ax.len - 1'b1;
    // FIXED repeats the address, WRAP is never presented
    if (ax.burst == BURST_INCR) begin
      nx.addr = ax.addr + (addr_t'(1) << ax.size);
    end
    return nx;
  endfunction

  // --------------------------------------
  // Splitter FSM
  // --------------------------------------
  always_comb begin
    state_d     = state_q;
    burst_d     = burst_q;
    ax_o        = '0;
    ax_valid_o  = 1'b0;
    ax_ready_o  = 1'b0;
    alloc_req_o = 1'b0;

    case (state_q)
      SplitIdle: begin
        // Nothing is offered without a free counter
        if (ax_valid_i && alloc_gnt_i) begin
          ax_o       = ax_i;
          ax_o.len   = '0;
          ax_valid_o = 1'b1;
          if (ax_i.len == '0) begin
            // Single beat, straight through
            ax_ready_o = ax_ready_i;
          end else begin
            // Take the burst now and start with its first beat
            ax_ready_o = 1'b1;
            burst_d    = ax_ready_i ? next_beat(ax_i) : ax_i;
            state_d    = SplitBusy;
          end
          // Counter claimed on the upstream handshake
          alloc_req_o = ax_ready_o;
        end
      end

      SplitBusy: begin
        ax_o       = burst_q;
        ax_o.len   = '0;
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (burst_q.len == '0) begin
            // That was the final beat
            state_d = SplitIdle;
          end else begin
            burst_d = next_beat(burst_q);
          end
        end
      end

      default: state_d = SplitIdle;
    endcase
  end

  // --------------------------------------
  // Registers
  // --------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SplitIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    burst_q <= burst_d;
  end

endmodule

/* logic/r_last_rebuild.sv */
// --------------------------------------
// Forwards downstream R beats upstream and recomputes last from the
// read beat counters
// --------------------------------------
`timescale 1ns/100ps

module r_last_rebuild (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axi_bus_pkg::r_chan_t dn_r_i,
  input  logic                 dn_r_valid_i,
  output logic                 dn_r_ready_o,
  output axi_bus_pkg::r_chan_t up_r_o,
  output logic                 up_r_valid_o,
  input  logic                 up_r_ready_i,
  // Read counter table
  output axi_bus_pkg::id_t     lookup_id_o,
  output logic                 lookup_req_o,
  input  logic                 lookup_gnt_i,
  input  axi_bus_pkg::len_t    lookup_left_i,
  output logic                 consume_o
);
  import split_pkg::*;

  hold_state_e state_q, state_d;
  // Last flag kept while upstream stalls
  logic        last_q, last_d;

  assign lookup_id_o = dn_r_i.id;

  always_comb begin
    state_d      = state_q;
    last_d       = last_q;
    up_r_o       = dn_r_i;
    up_r_o.last  = 1'b0;
    up_r_valid_o = 1'b0;
    dn_r_ready_o = 1'b0;
    lookup_req_o = 1'b0;
    consume_o    = 1'b0;

    case (state_q)
      HoldPass: begin
        // Beats without a live burst of their ID stay downstream
        if (dn_r_valid_i) begin
          lookup_req_o = 1'b1;
          if (lookup_gnt_i) begin
            // Beat counted now, even if upstream is stalled
            consume_o    = 1'b1;
            last_d       = (lookup_left_i == '0);
            up_r_o.last  = last_d;
            up_r_valid_o = 1'b1;
            if (up_r_ready_i) begin
              dn_r_ready_o = 1'b1;
            end else begin
              state_d = HoldWait;
            end
          end
        end
      end

      HoldWait: begin
        // Counter already consumed, replay the stored flag
        up_r_o.last  = last_q;
        up_r_valid_o = dn_r_valid_i;
        dn_r_ready_o = up_r_ready_i;
        if (dn_r_valid_i && up_r_ready_i) begin
          state_d = HoldPass;
        end
      end

      default: state_d = HoldPass;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= HoldPass;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

endmodule

/* logic/b_merger.sv */
// --------------------------------------
// Folds the per-beat B responses of a split write into one upstream B
// carrying the worst response of the burst
// --------------------------------------
`timescale 1ns/100ps

module b_merger (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axi_bus_pkg::b_chan_t dn_b_i,
  input  logic                 dn_b_valid_i,
  output logic                 dn_b_ready_o,
  output axi_bus_pkg::b_chan_t up_b_o,
  output logic                 up_b_valid_o,
  input  logic                 up_b_ready_i,
  // Write counter table
  output axi_bus_pkg::id_t     lookup_id_o,
  output logic                 lookup_req_o,
  input  logic                 lookup_gnt_i,
  input  axi_bus_pkg::len_t    lookup_left_i,
  input  axi_bus_pkg::resp_e   worst_resp_i,
  output logic                 consume_o,
  output axi_bus_pkg::resp_e   consume_resp_o
);
  import axi_bus_pkg::*;

  // Merged B waiting for upstream, entry already released
  logic    held_q, held_d;
  b_chan_t b_q, b_d;
  resp_e   merged_resp;

  assign lookup_id_o    = dn_b_i.id;
  assign consume_resp_o = dn_b_i.resp;
  // Worst of the earlier beats and this one
  assign merged_resp    = worse_resp(worst_resp_i, dn_b_i.resp);

  always_comb begin
    held_d       = held_q;
    b_d          = b_q;
    up_b_o       = b_q;
    up_b_valid_o = 1'b0;
    dn_b_ready_o = 1'b0;
    lookup_req_o = 1'b0;
    consume_o    = 1'b0;

    if (held_q) begin
      up_b_valid_o = dn_b_valid_i;
      dn_b_ready_o = up_b_ready_i;
      if (dn_b_valid_i && up_b_ready_i) begin
        held_d = 1'b0;
      end
    end else if (dn_b_valid_i) begin
      lookup_req_o = 1'b1;
      if (lookup_gnt_i) begin
        consume_o = 1'b1;
        if (lookup_left_i != '0) begin
          // Intermediate beat, swallowed here
          dn_b_ready_o = 1'b1;
        end else begin
          // Final beat goes up with the merged response
          up_b_o.id    = dn_b_i.id;
          up_b_o.resp  = merged_resp;
          up_b_valid_o = 1'b1;
          dn_b_ready_o = up_b_ready_i;
          b_d          = up_b_o;
          held_d       = !up_b_ready_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else begin
      held_q <= held_d;
    end
  end

  always_ff @(posedge clk_i) begin
    b_q <= b_d;
  end

endmodule

/* logic/burst_splitter.sv */
// --------------------------------------
// AXI4 burst splitter top. Upstream bursts become single-beat requests
// for a subordinate that only takes len 0, responses are regrouped
// --------------------------------------
`timescale 1ns/100ps

module burst_splitter #(
  // Bursts outstanding per direction
  parameter int unsigned MAX_TXNS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Upstream manager side
  input  axi_bus_pkg::axi_req_t  slv_req_i,
  output axi_bus_pkg::axi_resp_t slv_resp_o,
  // Downstream subordinate side
  output axi_bus_pkg::axi_req_t  mst_req_o,
  input  axi_bus_pkg::axi_resp_t mst_resp_i
);
  import axi_bus_pkg::*;

  logic  ar_alloc_req, ar_alloc_gnt;
  logic  aw_alloc_req, aw_alloc_gnt;
  id_t   r_lookup_id, b_lookup_id;
  logic  r_lookup_req, r_lookup_gnt;
  logic  b_lookup_req, b_lookup_gnt;
  len_t  r_lookup_left, b_lookup_left;
  logic  r_consume, b_consume;
  resp_e b_consume_resp, b_worst_resp;

  // --------------------------------------
  // Read direction
  // --------------------------------------
  ax_splitter i_ar_split (
    .clk_i,
    .rst_ni,
    .ax_i        (slv_req_i.ar),
    .ax_valid_i  (slv_req_i.ar_valid),
    .ax_ready_o  (slv_resp_o.ar_ready),
    .ax_o        (mst_req_o.ar),
    .ax_valid_o  (mst_req_o.ar_valid),
    .ax_ready_i  (mst_resp_i.ar_ready),
    .alloc_req_o (ar_alloc_req),
    .alloc_gnt_i (ar_alloc_gnt)
  );

  // Reads only count beats, response folding stays idle
  beat_counters #(
    .MAX_TXNS (MAX_TXNS)
  ) i_r_cnt (
    .clk_i,
    .rst_ni,
    .alloc_ax_i     (slv_req_i.ar),
    .alloc_req_i    (ar_alloc_req),
    .alloc_gnt_o    (ar_alloc_gnt),
    .lookup_id_i    (r_lookup_id),
    .lookup_req_i   (r_lookup_req),
    .lookup_gnt_o   (r_lookup_gnt),
    .lookup_left_o  (r_lookup_left),
    .consume_i      (r_consume),
    .consume_resp_i (RESP_OKAY),
    .worst_resp_o   ()
  );

  r_last_rebuild i_r_last (
    .clk_i,
    .rst_ni,
    .dn_r_i        (mst_resp_i.r),
    .dn_r_valid_i  (mst_resp_i.r_valid),
    .dn_r_ready_o  (mst_req_o.r_ready),
    .up_r_o        (slv_resp_o.r),
    .up_r_valid_o  (slv_resp_o.r_valid),
    .up_r_ready_i  (slv_req_i.r_ready),
    .lookup_id_o   (r_lookup_id),
    .lookup_req_o  (r_lookup_req),
    .lookup_gnt_i  (r_lookup_gnt),
    .lookup_left_i (r_lookup_left),
    .consume_o     (r_consume)
  );

  // --------------------------------------
  // Write direction
  // --------------------------------------
  ax_splitter i_aw_split (
    .clk_i,
    .rst_ni,
    .ax_i        (slv_req_i.aw),
    .ax_valid_i  (slv_req_i.aw_valid),
    .ax_ready_o  (slv_resp_o.aw_ready),
    .ax_o        (mst_req_o.aw),
    .ax_valid_o  (mst_req_o.aw_valid),
    .ax_ready_i  (mst_resp_i.aw_ready),
    .alloc_req_o (aw_alloc_req),
    .alloc_gnt_i (aw_alloc_gnt)
  );

  beat_counters #(
    .MAX_TXNS (MAX_TXNS)
  ) i_b_cnt (
    .clk_i,
    .rst_ni,
    .alloc_ax_i     (slv_req_i.aw),
    .alloc_req_i    (aw_alloc_req),
    .alloc_gnt_o    (aw_alloc_gnt),
    .lookup_id_i    (b_lookup_id),
    .lookup_req_i   (b_lookup_req),
    .lookup_gnt_o   (b_lookup_gnt),
    .lookup_left_o  (b_lookup_left),
    .consume_i      (b_consume),
    .consume_resp_i (b_consume_resp),
    .worst_resp_o   (b_worst_resp)
  );

  // W beats each close their own single-beat burst
  assign mst_req_o.w.data   = slv_req_i.w.data;
  assign mst_req_o.w.strb   = slv_req_i.w.strb;
  assign mst_req_o.w.last   = 1'b1;
  assign mst_req_o.w_valid  = slv_req_i.w_valid;
  assign slv_resp_o.w_ready = mst_resp_i.w_ready;

  b_merger i_b_merge (
    .clk_i,
    .rst_ni,
    .dn_b_i         (mst_resp_i.b),
    .dn_b_valid_i   (mst_resp_i.b_valid),
    .dn_b_ready_o   (mst_req_o.b_ready),
    .up_b_o         (slv_resp_o.b),
    .up_b_valid_o   (slv_resp_o.b_valid),
    .up_b_ready_i   (slv_req_i.b_ready),
    .lookup_id_o    (b_lookup_id),
    .lookup_req_o   (b_lookup_req),
    .lookup_gnt_i   (b_lookup_gnt),
    .lookup_left_i  (b_lookup_left),
    .worst_resp_i   (b_worst_resp),
    .consume_o      (b_consume),
    .consume_resp_o (b_consume_resp)
  );

endmodule

/* tests/tb_burst_splitter.sv */
// --------------------------------------
// Testbench for the burst splitter: replays bursts from the cases file
// against a single-beat subordinate model and checks both sides
// --------------------------------------
`timescale 1ns/100ps

module tb_burst_splitter;
  import axi_bus_pkg::*;

  localparam int unsigned MaxTxns    = 4;
  // Cycles the blocked burst must stay unaccepted
  localparam int unsigned HoldCycles = 20;

  logic      clk_i;
  logic      rst_ni;
  axi_req_t  req_drv, slv_req, mst_req;
  axi_resp_t slv_resp, mst_resp;
  logic      up_r_ready, up_b_ready;

  // Case table from the file
  ax_chan_t  case_ax[$];
  byte       case_kind[$];
  // Expected traffic
  ax_chan_t  exp_ar_q[$], exp_aw_q[$];
  logic      exp_ar_err[$], exp_aw_err[$];
  w_chan_t   exp_w_q[$];
  r_chan_t   exp_r_q[$];
  b_chan_t   exp_b_q[$];
  // Subordinate model state
  r_chan_t   r_ret_q[$];
  b_chan_t   b_ret_q[$], aw_pend_q[$];
  int        w_cnt;
  logic      r_busy, b_busy, hold_resp;
  int        issued, received, total_resp;
  int        cycle_cnt, cycle_limit;

  burst_splitter #(
    .MAX_TXNS (MaxTxns)
  ) dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  always #2 clk_i = ~clk_i;

  // Upstream ready lines come from the response side of the model
  always_comb begin
    slv_req         = req_drv;
    slv_req.r_ready = up_r_ready;
    slv_req.b_ready = up_b_ready;
  end

  // --------------------------------------
  // Failure reporting and compare tasks
  // --------------------------------------
  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_ax(input string name, input ax_chan_t exp, input ax_chan_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_w(input string name, input w_chan_t exp, input w_chan_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_r(input string name, input r_chan_t exp, input r_chan_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_b(input string name, input b_chan_t exp, input b_chan_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic report(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  // Oldest queued element with a given ID, -1 if none
  function automatic int first_r_of(ref r_chan_t q[$], input id_t id);
    for (int i = 0; i < q.size(); i++) begin
      if (q[i].id == id) return i;
    end
    return -1;
  endfunction

  function automatic int first_b_of(ref b_chan_t q[$], input id_t id);
    for (int i = 0; i < q.size(); i++) begin
      if (q[i].id == id) return i;
    end
    return -1;
  endfunction

  // Address of beat n per the AXI burst rules
  function automatic addr_t beat_addr(input ax_chan_t ax, input int n);
    if (ax.burst == BURST_FIXED) return ax.addr;
    return ax.addr + addr_t'(n) * (addr_t'(1) << ax.size);
  endfunction

  // --------------------------------------
  // Case file and expected traffic
  // --------------------------------------
  task automatic load_cases();
    int       fd, beats;
    string    line;
    byte      kind;
    int       v[6];
    ax_chan_t ax, beat;
    fd    = $fopen("tests/split_cases.txt", "r");
    beats = 0;
    if (fd == 0) report("Cannot open tests/split_cases.txt");
    while ($fgets(line, fd)) begin
      if (line.len() < 3 || line[0] == "#") continue;
      void'($sscanf(line, "%c %h %h %h %h %h %h", kind, v[0], v[1], v[2], v[3], v[4], v[5]));
      ax.id    = id_t'(v[0]);
      ax.addr  = addr_t'(v[1]);
      ax.len   = len_t'(v[2]);
      ax.size  = size_t'(v[3]);
      ax.burst = burst_e'(v[4][1:0]);
      case_ax.push_back(ax);
      case_kind.push_back(kind);
      beats += ax.len + 1;
      for (int i = 0; i <= ax.len; i++) begin
        beat      = ax;
        beat.len  = '0;
        beat.addr = beat_addr(ax, i);
        if (kind == "W") begin
          exp_aw_q.push_back(beat);
          exp_aw_err.push_back(i == v[5]);
        end else begin
          exp_ar_q.push_back(beat);
          exp_ar_err.push_back(i == v[5]);
          exp_r_q.push_back('{id: ax.id, data: beat.addr,
                             resp: (i == v[5]) ? RESP_SLVERR : RESP_OKAY,
                             last: (i == ax.len)});
        end
      end
      if (kind == "W") begin
        exp_b_q.push_back('{id: ax.id, resp: (v[5] <= ax.len) ? RESP_SLVERR : RESP_OKAY});
      end
    end
    $fclose(fd);
    total_resp  = exp_r_q.size() + exp_b_q.size();
    cycle_limit = 200 * beats + 100;
  endtask

  // --------------------------------------
  // Upstream driver
  // --------------------------------------
  task automatic send_ar(input ax_chan_t ax, input logic blocked);
    @(negedge clk_i);
    req_drv.ar       = ax;
    req_drv.ar_valid = 1'b1;
    // All read counters taken, the burst must wait for a release
    if (blocked) begin
      for (int i = 0; i < HoldCycles; i++) begin
        #1;
        if (slv_resp.ar_ready) report("AR accepted while all read counters were busy");
        @(negedge clk_i);
      end
      hold_resp = 1'b0;
    end
    #1;
    while (!slv_resp.ar_ready) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req_drv.ar_valid = 1'b0;
  endtask

  task automatic send_write(input ax_chan_t ax);
    w_chan_t w;
    @(negedge clk_i);
    req_drv.aw       = ax;
    req_drv.aw_valid = 1'b1;
    #1;
    while (!slv_resp.aw_ready) begin
      @(negedge clk_i);
      #1;
    end
    for (int i = 0; i <= ax.len; i++) begin
      @(negedge clk_i);
      req_drv.aw_valid = 1'b0;
      w.data           = $urandom;
      w.strb           = '1;
      w.last           = (i == ax.len);
      req_drv.w        = w;
      req_drv.w_valid  = 1'b1;
      // Downstream sees every beat as the last of its own burst
      w.last           = 1'b1;
      exp_w_q.push_back(w);
      #1;
      while (!slv_resp.w_ready) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    req_drv.w_valid = 1'b0;
  endtask

  initial begin : driver
    int held;
    held       = 0;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    req_drv    = '0;
    hold_resp  = 1'b0;
    issued     = 0;
    cycle_limit = 0;
    void'($urandom(70512));
    load_cases();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int c = 0; c < case_ax.size(); c++) begin
      if (case_kind[c] == "S") begin
        // Drain everything, then stall the responses
        if (held == 0) begin
          while (received != issued) @(negedge clk_i);
          hold_resp = 1'b1;
        end
        issued += case_ax[c].len + 1;
        send_ar(case_ax[c], held >= MaxTxns);
        held++;
      end else if (case_kind[c] == "R") begin
        issued += case_ax[c].len + 1;
        send_ar(case_ax[c], 1'b0);
      end else begin
        issued += 1;
        send_write(case_ax[c]);
      end
    end

    while (received != total_resp) @(negedge clk_i);
    // Room for any stray response
    repeat (10) @(negedge clk_i);
    if (exp_ar_q.size() != 0 || exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
      $display("Downstream requests still missing at end of run");
      $display("TEST FAIL");
      $fatal(1, "Incomplete downstream traffic");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  // --------------------------------------
  // Downstream subordinate model and upstream monitor
  // --------------------------------------
  initial begin : subordinate
    int idx;
    mst_resp   = '0;
    up_r_ready = 1'b0;
    up_b_ready = 1'b0;
    r_busy     = 1'b0;
    b_busy     = 1'b0;
    w_cnt      = 0;
    received   = 0;
    forever begin
      @(negedge clk_i);
      mst_resp.ar_ready = ($urandom % 4) != 0;
      mst_resp.aw_ready = ($urandom % 4) != 0;
      mst_resp.w_ready  = ($urandom % 4) != 0;
      up_r_ready        = ($urandom % 4) != 0;
      up_b_ready        = ($urandom % 4) != 0;
      // Answer a random ID, oldest first within that ID
      if (!r_busy && !hold_resp && r_ret_q.size() > 0) begin
        idx          = first_r_of(r_ret_q, r_ret_q[$urandom % r_ret_q.size()].id);
        mst_resp.r   = r_ret_q[idx];
        r_ret_q.delete(idx);
        r_busy       = 1'b1;
      end
      if (!b_busy && !hold_resp && b_ret_q.size() > 0) begin
        idx          = first_b_of(b_ret_q, b_ret_q[$urandom % b_ret_q.size()].id);
        mst_resp.b   = b_ret_q[idx];
        b_ret_q.delete(idx);
        b_busy       = 1'b1;
      end
      mst_resp.r_valid = r_busy;
      mst_resp.b_valid = b_busy;

      #1;
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        if (exp_ar_q.size() == 0) report("Unexpected downstream AR beat");
        check_ax("mst_req_o.ar", exp_ar_q[0], mst_req.ar);
        r_ret_q.push_back('{id: mst_req.ar.id, data: mst_req.ar.addr,
                           resp: exp_ar_err[0] ? RESP_SLVERR : RESP_OKAY, last: 1'b1});
        void'(exp_ar_q.pop_front());
        void'(exp_ar_err.pop_front());
      end
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        if (exp_aw_q.size() == 0) report("Unexpected downstream AW beat");
        check_ax("mst_req_o.aw", exp_aw_q[0], mst_req.aw);
        aw_pend_q.push_back('{id: mst_req.aw.id,
                             resp: exp_aw_err[0] ? RESP_SLVERR : RESP_OKAY});
        void'(exp_aw_q.pop_front());
        void'(exp_aw_err.pop_front());
      end
      if (mst_req.w_valid && mst_resp.w_ready) begin
        if (exp_w_q.size() == 0) report("Unexpected downstream W beat");
        check_w("mst_req_o.w", exp_w_q.pop_front(), mst_req.w);
        w_cnt++;
      end
      // A single-beat write answers once both address and data are in
      while (aw_pend_q.size() > 0 && w_cnt > 0) begin
        b_ret_q.push_back(aw_pend_q.pop_front());
        w_cnt--;
      end
      if (mst_resp.r_valid && mst_req.r_ready) r_busy = 1'b0;
      if (mst_resp.b_valid && mst_req.b_ready) b_busy = 1'b0;

      if (slv_resp.r_valid && up_r_ready) begin
        idx = first_r_of(exp_r_q, slv_resp.r.id);
        if (idx < 0) report("Upstream R beat with an ID that owes no data");
        check_r("slv_resp_o.r", exp_r_q[idx], slv_resp.r);
        exp_r_q.delete(idx);
        received++;
      end
      if (slv_resp.b_valid && up_b_ready) begin
        idx = first_b_of(exp_b_q, slv_resp.b.id);
        if (idx < 0) report("Upstream B response with an ID that owes none");
        check_b("slv_resp_o.b", exp_b_q[idx], slv_resp.b);
        exp_b_q.delete(idx);
        received++;
      end
    end
  end

  // Watchdog sized from the beats in the case file
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: responses still missing after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "Watchdog expired");
    end
  end

  initial cycle_cnt = 0;

endmodule

/* tests/split_cases.txt */
# kind id addr len size burst slverr_beat, all hex; kind R read, W write, S read with responses held
# burst 0 FIXED, 1 INCR; slverr_beat FF for none
R 1 00001000 00 2 1 FF
R 2 00002000 03 2 1 FF
W 3 00003000 03 2 1 01
W 4 00004000 00 2 1 FF
R 5 00005000 02 2 0 01
R 1 00001100 01 1 1 FF
W 3 00003100 02 2 0 FF
R 6 00006000 07 2 1 FF
W 7 00007000 00 2 1 00
R 2 00002100 00 0 1 00
W 8 00008000 05 2 1 05
R 6 00006100 03 0 1 FF
W 4 00004100 01 1 1 FF
R 9 00009000 0F 2 1 0A
W 9 00009100 07 2 1 FF
R 3 0000A000 01 2 0 FF
W A 0000B000 02 2 1 02
R 1 0000C000 02 2 1 FF
S 8 0000D000 01 2 1 FF
S 9 0000D100 01 2 1 FF
S A 0000D200 01 2 1 FF
S B 0000D300 01 2 1 FF
S C 0000D400 01 2 1 FF

/* src.f */
logic/axi_bus_pkg.sv
logic/split_pkg.sv
logic/beat_counters.sv
logic/ax_splitter.sv
logic/r_last_rebuild.sv
logic/b_merger.sv
logic/burst_splitter.sv
tests/tb_burst_splitter.sv

/* Bender.yml */
package:
  name: burst_splitter

sources:
  - logic/axi_bus_pkg.sv
  - logic/split_pkg.sv
  - logic/beat_counters.sv
  - logic/ax_splitter.sv
  - logic/r_last_rebuild.sv
  - logic/b_merger.sv
  - logic/burst_splitter.sv
  - target: test
    files:
      - tests/tb_burst_splitter.sv
